/* logic/gameover_pkg.sv */
package gameover_pkg;

   // raster and value widths
   typedef logic [11:0] hpos_t;
   typedef logic [10:0] vpos_t;
   typedef logic [3:0]  digit_t;          // 10 to 15 draw nothing
   typedef logic [6:0]  tile_coord_t;     // 0..127 inside a tile

   typedef struct packed
   {
      logic [7:0] r;
      logic [7:0] g;
      logic [7:0] b;
   } rgb_t;

   // one field's view of the current pixel after the locator stage
   typedef struct packed
   {
      logic        hit;                   // pixel lies inside the tile
      tile_coord_t x;
      tile_coord_t y;
      digit_t      digit;
   } tile_req_t;

   localparam int unsigned max_fields  = 4;
   localparam int unsigned tile_size   = 128;
   localparam int unsigned cell_shift  = 4;     // 16x16 pixel cells, 8x8 per tile
   localparam int unsigned score_row_y = 850;

   // left edges on the score row
   localparam hpos_t field_x0 [max_fields] = '{
      12'd330,                            // tens of seconds
      12'd480,                            // units of seconds
      12'd1050,                           // correct answers
      12'd1620                            // wrong answers
   };

   localparam rgb_t field_ink [max_fields] = '{
      '{r: 8'hff, g: 8'hff, b: 8'hff},    // time in white
      '{r: 8'hff, g: 8'hff, b: 8'hff},
      '{r: 8'h00, g: 8'hff, b: 8'h00},    // correct in green
      '{r: 8'hff, g: 8'h00, b: 8'h00}     // wrong in red
   };

endpackage

/* logic/field_locator.sv */
`timescale 1ns/1ps

module field_locator
   import gameover_pkg::*;
#(
   parameter int num_fields = 4
)
(
   input  logic                       clk,
   input  logic                       reset,
   input  hpos_t                      hcnt,
   input  vpos_t                      vcnt,
   input  digit_t    [num_fields-1:0] counts,
   output tile_req_t [num_fields-1:0] req
);

   vpos_t                        dy;
   logic                         row_hit;
   hpos_t       [num_fields-1:0] dx;
   logic        [num_fields-1:0] col_hit;

   logic        [num_fields-1:0] hit_q;
   tile_coord_t [num_fields-1:0] x_q;
   tile_coord_t [num_fields-1:0] y_q;
   digit_t      [num_fields-1:0] digit_q;

   // all tiles share the score row
   assign dy      = vcnt - vpos_t'(score_row_y);
   assign row_hit = dy < vpos_t'(tile_size);   // wraps above the row

   always_comb
   begin
      for (int i = 0; i < num_fields; i++)
      begin
         dx[i]      = hcnt - field_x0[i];
         col_hit[i] = dx[i] < hpos_t'(tile_size);
      end
   end

   always_ff @(posedge clk or negedge reset)
   begin
      if (!reset)
      begin
         hit_q <= '0;
      end
      else
      begin
         for (int i = 0; i < num_fields; i++)
         begin
            hit_q[i] <= row_hit & col_hit[i];
         end
      end
   end

   // tile-local position and value, only meaningful with hit
   always_ff @(posedge clk)
   begin
      for (int i = 0; i < num_fields; i++)
      begin
         x_q[i]     <= dx[i][6:0];
         y_q[i]     <= dy[6:0];
         digit_q[i] <= counts[i];
      end
   end

   always_comb
   begin
      for (int i = 0; i < num_fields; i++)
      begin
         req[i].hit   = hit_q[i];
         req[i].x     = x_q[i];
         req[i].y     = y_q[i];
         req[i].digit = digit_q[i];
      end
   end

endmodule

/* logic/digit_tile.sv */
`timescale 1ns/1ps

module digit_tile
   import gameover_pkg::*;
(
   input  logic      clk,
   input  logic      reset,
   input  tile_req_t req,
   output logic      lit
);

   logic [2:0] col;
   logic [2:0] row;
   logic [6:0] cell_seg;     // {g, f, e, d, c, b, a}
   logic [6:0] digit_seg;
   logic       upper;
   logic       lower;
   logic       inner;

   // 16x16 pixel cells
   assign col = 3'(req.x >> cell_shift);
   assign row = 3'(req.y >> cell_shift);

   assign inner = (col != 3'd0) && (col != 3'd7);
   assign upper = (row == 3'd1) || (row == 3'd2);
   assign lower = (row >= 3'd4) && (row <= 3'd6);

   // which segment, if any, covers this cell
   always_comb
   begin
      cell_seg    = '0;
      cell_seg[0] = (row == 3'd0) && inner;    // a
      cell_seg[1] = (col == 3'd7) && upper;    // b
      cell_seg[2] = (col == 3'd7) && lower;    // c
      cell_seg[3] = (row == 3'd7) && inner;    // d
      cell_seg[4] = (col == 3'd0) && lower;    // e
      cell_seg[5] = (col == 3'd0) && upper;    // f
      cell_seg[6] = (row == 3'd3) && inner;    // g
   end

   always_comb
   begin
      case (req.digit)
         4'd0:    digit_seg = 7'b0111111;
         4'd1:    digit_seg = 7'b0000110;
         4'd2:    digit_seg = 7'b1011011;
         4'd3:    digit_seg = 7'b1001111;
         4'd4:    digit_seg = 7'b1100110;
         4'd5:    digit_seg = 7'b1101101;
         4'd6:    digit_seg = 7'b1111101;
         4'd7:    digit_seg = 7'b0000111;
         4'd8:    digit_seg = 7'b1111111;
         4'd9:    digit_seg = 7'b1101111;
         default: digit_seg = 7'b0000000;   // not a decimal digit, blank tile
      endcase
   end

   always_ff @(posedge clk or negedge reset)
   begin
      if (!reset)
      begin
         lit <= 1'b0;
      end
      else
      begin
         lit <= req.hit & (|(cell_seg & digit_seg));
      end
   end

endmodule

/* logic/pixel_compositor.sv */
`timescale 1ns/1ps

module pixel_compositor
   import gameover_pkg::*;
#(
   parameter int   num_fields = 4,
   parameter rgb_t background = '{r: 8'h32, g: 8'h32, b: 8'h32},
   parameter rgb_t blank      = '{r: 8'h00, g: 8'h00, b: 8'h00}
)
(
   input  logic                  clk,
   input  logic                  reset,
   input  logic [num_fields-1:0] lit,
   output rgb_t                  color
);

   rgb_t color_n;

   // tiles never overlap on screen, but lowest index wins anyway
   always_comb
   begin
      color_n = background;
      for (int i = num_fields - 1; i >= 0; i--)
      begin
         if (lit[i])
         begin
            color_n = field_ink[i];
         end
      end
   end

   always_ff @(posedge clk or negedge reset)
   begin
      if (!reset)
      begin
         color <= blank;
      end
      else
      begin
         color <= color_n;
      end
   end

endmodule

/* logic/gameover_screen.sv */
`timescale 1ns/1ps

module gameover_screen
   import gameover_pkg::*;
#(
   parameter int   num_fields = 4,
   parameter rgb_t background = '{r: 8'h32, g: 8'h32, b: 8'h32},
   parameter rgb_t blank      = '{r: 8'h00, g: 8'h00, b: 8'h00}
)
(
   input  logic   clk,
   input  logic   reset,
   input  hpos_t  hcnt,
   input  vpos_t  vcnt,
   input  digit_t sec_tens,
   input  digit_t sec_units,
   input  digit_t correct_count,
   input  digit_t wrong_count,
   output rgb_t   color
);

   digit_t    [max_fields-1:0] all_counts;
   tile_req_t [num_fields-1:0] req;
   logic      [num_fields-1:0] lit;

   // field order matches the origin and ink tables
   assign all_counts = {wrong_count, correct_count, sec_units, sec_tens};

   field_locator #(
      .num_fields (num_fields)
   ) field_locator_inst (
      .clk    (clk),
      .reset  (reset),
      .hcnt   (hcnt),
      .vcnt   (vcnt),
      .counts (all_counts[num_fields-1:0]),
      .req    (req)
   );

   for (genvar i = 0; i < num_fields; i++)
   begin : g_tile
      digit_tile digit_tile_inst (
         .clk   (clk),
         .reset (reset),
         .req   (req[i]),
         .lit   (lit[i])
      );
   end

   pixel_compositor #(
      .num_fields (num_fields),
      .background (background),
      .blank      (blank)
   ) pixel_compositor_inst (
      .clk   (clk),
      .reset (reset),
      .lit   (lit),
      .color (color)
   );

endmodule

/* tests/gameover_screen_assertions.sv */
`timescale 1ns/1ps

module gameover_screen_assertions
   import gameover_pkg::*;
#(
   parameter rgb_t background = '{r: 8'h32, g: 8'h32, b: 8'h32},
   parameter rgb_t blank      = '{r: 8'h00, g: 8'h00, b: 8'h00}
)
(
   input logic clk,
   input logic reset,
   input rgb_t color
);

   // background or one of the field inks
   function automatic logic known_color(rgb_t c);
      logic found;
      found = (c == background);
      for (int i = 0; i < int'(max_fields); i++)
      begin
         if (c == field_ink[i])
         begin
            found = 1'b1;
         end
      end
      return found;
   endfunction

   blank_in_reset: assert property (@(posedge clk) !reset |-> color == blank)
      else $error("color is not blank while reset is low");

   background_after_release: assert property (@(posedge clk) disable iff (!reset)
      $rose(reset) |=> color == background)
      else $error("color is not background right after reset release");

   palette_only: assert property (@(posedge clk) disable iff (!reset)
      $past(reset) |-> known_color(color))
      else $error("color is neither background nor a field ink");

endmodule

/* tests/gameover_screen_tb.sv */
`timescale 1ns/1ps

module gameover_screen_tb
   import gameover_pkg::*;
;

   localparam int   num_fields     = 4;
   localparam rgb_t background     = '{r: 8'h32, g: 8'h32, b: 8'h32};
   localparam rgb_t blank          = '{r: 8'h00, g: 8'h00, b: 8'h00};
   localparam int   timeout_cycles = 6000;   // tests take about 4800

   logic   clk = 1'b0;
   logic   reset;
   hpos_t  hcnt;
   vpos_t  vcnt;
   digit_t sec_tens;
   digit_t sec_units;
   digit_t correct_count;
   digit_t wrong_count;
   rgb_t   color;

   rgb_t        expected_q [3];             // matches the three pipeline stages
   digit_t      sampled_counts [max_fields];
   logic        in_reset_q = 1'b1;          // last edge was under reset
   logic [31:0] lcg_state = 32'heaa;
   int          cycles = 0;

   gameover_screen #(
      .num_fields (num_fields),
      .background (background),
      .blank      (blank)
   ) gameover_screen_inst (
      .clk           (clk),
      .reset         (reset),
      .hcnt          (hcnt),
      .vcnt          (vcnt),
      .sec_tens      (sec_tens),
      .sec_units     (sec_units),
      .correct_count (correct_count),
      .wrong_count   (wrong_count),
      .color         (color)
   );

   bind gameover_screen gameover_screen_assertions #(
      .background (background),
      .blank      (blank)
   ) gameover_screen_assertions_inst (
      .clk   (clk),
      .reset (reset),
      .color (color)
   );

   always #2 clk = ~clk;

   function automatic logic [31:0] lcg_next();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   // segment letters lit by each decimal digit
   function automatic string digit_segments(digit_t d);
      case (d)
         4'd0:    return "abcdef";
         4'd1:    return "bc";
         4'd2:    return "abdeg";
         4'd3:    return "abcdg";
         4'd4:    return "bcfg";
         4'd5:    return "acdfg";
         4'd6:    return "acdefg";
         4'd7:    return "abc";
         4'd8:    return "abcdefg";
         4'd9:    return "abcdfg";
         default: return "";
      endcase
   endfunction

   function automatic byte cell_segment(int col, int row);
      if (row == 0 && col >= 1 && col <= 6) return "a";
      if (row == 3 && col >= 1 && col <= 6) return "g";
      if (row == 7 && col >= 1 && col <= 6) return "d";
      if (col == 0 && (row == 1 || row == 2)) return "f";
      if (col == 7 && (row == 1 || row == 2)) return "b";
      if (col == 0 && row >= 4 && row <= 6) return "e";
      if (col == 7 && row >= 4 && row <= 6) return "c";
      return " ";
   endfunction

   // reference pixel for one raster position and set of counts
   function automatic rgb_t expected_color(int h, int v, digit_t cnt [max_fields]);
      int    dx;
      int    dy;
      string segs;
      byte   seg;
      dy = v - int'(score_row_y);
      if (dy < 0 || dy >= int'(tile_size)) return background;
      for (int i = 0; i < num_fields; i++)
      begin
         dx = h - int'(field_x0[i]);
         if (dx >= 0 && dx < int'(tile_size))
         begin
            seg  = cell_segment(dx / 16, dy / 16);
            segs = digit_segments(cnt[i]);
            for (int k = 0; k < segs.len(); k++)
            begin
               if (segs[k] == seg) return field_ink[i];
            end
            return background;
         end
      end
      return background;
   endfunction

   task automatic check_color(string name, rgb_t expected, rgb_t actual);
      if (actual !== expected)
      begin
         $display("ERROR %s expected %06h actual %06h at %0t", name, expected, actual, $time);
         $display("ERRORS FOUND");
         $fatal(1, "output color mismatch");
      end
   endtask

   task automatic drive_pixel(int h, int v, digit_t cnt [max_fields]);
      @(posedge clk);
      #1;
      hcnt          = hpos_t'(h);
      vcnt          = vpos_t'(v);
      sec_tens      = cnt[0];
      sec_units     = cnt[1];
      correct_count = cnt[2];
      wrong_count   = cnt[3];
   endtask

   // all 64 cell centers of one tile
   task automatic sweep_tile(int field, digit_t value);
      digit_t cnt [max_fields];
      cnt = '{default: value};
      for (int row = 0; row < 8; row++)
      begin
         for (int col = 0; col < 8; col++)
         begin
            drive_pixel(int'(field_x0[field]) + col * 16 + 8,
                        int'(score_row_y) + row * 16 + 8, cnt);
         end
      end
   endtask

   // cells that an 8 would light, plus one inner cell
   task automatic probe_blank(int field, digit_t value);
      int     pcol [8];
      int     prow [8];
      digit_t cnt [max_fields];
      pcol = '{0, 0, 7, 7, 3, 3, 3, 4};
      prow = '{1, 5, 2, 4, 0, 3, 7, 5};
      cnt  = '{default: value};
      for (int k = 0; k < 8; k++)
      begin
         drive_pixel(int'(field_x0[field]) + pcol[k] * 16 + 8,
                     int'(score_row_y) + prow[k] * 16 + 8, cnt);
      end
   endtask

   task automatic probe_edges(int field);
      digit_t cnt [max_fields];
      int     x0;
      int     y0;
      cnt = '{default: 4'd8};
      x0  = int'(field_x0[field]);
      y0  = int'(score_row_y);
      drive_pixel(x0 - 1, y0 + 24, cnt);     // through segment f
      drive_pixel(x0, y0 + 24, cnt);
      drive_pixel(x0 + 127, y0 + 24, cnt);   // through segment b
      drive_pixel(x0 + 128, y0 + 24, cnt);
      drive_pixel(x0 + 64, y0 - 1, cnt);     // through segment a
      drive_pixel(x0 + 64, y0, cnt);
      drive_pixel(x0 + 64, y0 + 127, cnt);   // through segment d
      drive_pixel(x0 + 64, y0 + 128, cnt);
   endtask

   // expected values follow the DUT registers
   always @(posedge clk)
   begin
      in_reset_q = !reset;
      if (!reset)
      begin
         expected_q[0] = background;
         expected_q[1] = background;
         expected_q[2] = background;
      end
      else
      begin
         sampled_counts[0] = sec_tens;
         sampled_counts[1] = sec_units;
         sampled_counts[2] = correct_count;
         sampled_counts[3] = wrong_count;
         expected_q[2] = expected_q[1];
         expected_q[1] = expected_q[0];
         expected_q[0] = expected_color(int'(hcnt), int'(vcnt), sampled_counts);
      end
   end

   always @(negedge clk)
   begin
      if (!reset || in_reset_q)
         check_color("color", blank, color);
      else
         check_color("color", expected_q[2], color);
   end

   always @(posedge clk)
   begin
      cycles++;
      if (cycles >= timeout_cycles)
      begin
         $display("ERRORS FOUND");
         $fatal(1, "run did not finish within %0d cycles", timeout_cycles);
      end
   end

   initial
   begin
      digit_t      cnt [max_fields];
      logic [31:0] r1;
      logic [31:0] r2;
      int          f;
      reset         = 1'b1;
      hcnt          = hpos_t'(int'(field_x0[0]) + 64);   // segment a of an 8
      vcnt          = vpos_t'(int'(score_row_y) + 8);
      sec_tens      = 4'd8;
      sec_units     = 4'd8;
      correct_count = 4'd8;
      wrong_count   = 4'd8;
      cnt           = '{default: 4'd0};
      #1;
      reset = 1'b0;
      repeat (5) @(posedge clk);
      #1;
      reset = 1'b1;
      hcnt  = '0;
      vcnt  = '0;
      repeat (4) drive_pixel(0, 0, cnt);   // pipeline fills with background

      for (int fld = 0; fld < num_fields; fld++)
      begin
         for (int d = 0; d < 10; d++)
            sweep_tile(fld, digit_t'(d));
      end

      for (int d = 10; d < 16; d++)
      begin
         for (int fld = 0; fld < num_fields; fld++)
            probe_blank(fld, digit_t'(d));
      end

      for (int fld = 0; fld < num_fields; fld++)
         probe_edges(fld);

      // new pixel every cycle, mostly around the tiles
      for (int n = 0; n < 2000; n++)
      begin
         r1     = lcg_next();
         r2     = lcg_next();
         cnt[0] = r2[19:16];
         cnt[1] = r2[23:20];
         cnt[2] = r2[27:24];
         cnt[3] = r2[31:28];
         if (r1[31:30] == 2'd0)
         begin
            drive_pixel(int'(r1[27:16]), int'(r1[15:5]), cnt);
         end
         else
         begin
            f = int'(r1[29:28]) % num_fields;
            drive_pixel(int'(field_x0[f]) + int'(r1[27:20]) % 160 - 16,
                        int'(score_row_y) + int'(r1[19:12]) % 160 - 16, cnt);
         end
      end

      // picture and title areas above and below the score row
      cnt = '{default: 4'd8};
      for (int k = 0; k < 12; k++)
      begin
         if (k < 8)
            drive_pixel((k * 347) % 1920, k * 97, cnt);
         else
            drive_pixel((k * 211) % 1920, 990 + k * 7, cnt);
      end

      repeat (5) @(negedge clk);
      #1;
      $display("NO ERRORS");
      $finish;
   end

endmodule

/* sources.f */
logic/gameover_pkg.sv
logic/field_locator.sv
logic/digit_tile.sv
logic/pixel_compositor.sv
logic/gameover_screen.sv
tests/gameover_screen_assertions.sv
tests/gameover_screen_tb.sv

/* Makefile */
# Verilator simulation of the game-over score block

TOP := gameover_screen_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f sources.f --top-module $(TOP) \
		-Mdir obj_dir -o $(TOP)_sim
	./obj_dir/$(TOP)_sim

clean:
	rm -rf obj_dir
